/* files.f */
hdl/conf_pkg.sv
hdl/conf_field_if.sv
hdl/conf_mem_if.sv
hdl/conf_word_counter.sv
hdl/conf_sequencer.sv
hdl/conf_reg_bank.sv
hdl/conf_mem.sv
hdl/conf_top.sv
verification/conf_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the configuration block testbench with Verilator, run it,
# then decide pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

log_file=sim.log
rm -f "$log_file"

verilator --binary --timing --assert -f files.f --top-module conf_tb -o conf_tb_sim \
   && ./obj_dir/conf_tb_sim | tee "$log_file" \
   || { echo "build or simulation run failed"; exit 1; }

grep -q "^STATUS: PASS$" "$log_file" \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation failed, see $log_file"; exit 1; }

/* verification/conf_tb.sv */
module conf_tb import conf_pkg::*; ();

   localparam int reset_cycles = 10;
   localparam int max_hold = 6;
   localparam int max_gap = 5;

   // worst case edges per operation: launch, latency, hold and release
   localparam int reg_cycles = 4 + max_hold;
   localparam int save_cycles = conf_fields + 4 + max_hold;
   localparam int load_cycles = conf_fields + 5 + max_hold;

   // operations summed over all tests
   localparam int n_reg = 72;
   localparam int n_save = 5;
   localparam int n_load = 9;
   localparam int timeout_cycles = 2 * (reset_cycles + 2 + max_gap + n_reg * reg_cycles
                                        + n_save * save_cycles + n_load * load_cycles);

   logic      clk;
   logic      arst_n;
   logic      ctr_req;
   logic      ctr_rnw;
   ctr_addr_t ctr_addr;
   data_t     ctr_data;
   logic      ctr_ack;
   data_t     ctr_rdata;
   conf_t     conf_out;

   // reference model of live fields and saved slots
   data_t model_field [conf_fields];
   data_t model_slot [conf_slots][conf_fields];

   int fail_cnt = 0;
   int tests_passed = 0;
   int tests_failed = 0;

   conf_top i_conf_top (
      .clk       (clk),
      .arst_n    (arst_n),
      .ctr_req   (ctr_req),
      .ctr_rnw   (ctr_rnw),
      .ctr_addr  (ctr_addr),
      .ctr_data  (ctr_data),
      .ctr_ack   (ctr_ack),
      .ctr_rdata (ctr_rdata),
      .conf_out  (conf_out)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   task automatic log_error(input string msg);
      fail_cnt++;
      $display("%s at time %0t", msg, $time);
   endtask

   task automatic log_mismatch(input string name, input conf_t exp, input conf_t act);
      fail_cnt++;
      $display("[FAIL] %s expected 0x%0h got 0x%0h at time %0t", name, exp, act, $time);
   endtask

   // handshake rules
   assert property (@(posedge clk) disable iff (!arst_n)
      (!ctr_req && !ctr_ack) |=> !ctr_ack)
      else log_error("ack rose while req was low");

   assert property (@(posedge clk) disable iff (!arst_n)
      (ctr_req && ctr_ack) |=> ctr_ack)
      else log_error("ack fell while req was still held");

   assert property (@(posedge clk) disable iff (!arst_n)
      (!ctr_req && ctr_ack) |=> !ctr_ack)
      else log_error("ack did not fall one edge after req fell");

   assert property (@(posedge clk) disable iff (!arst_n)
      !ctr_ack |-> (ctr_rdata == '0))
      else log_mismatch("ctr_rdata", '0, conf_t'(ctr_rdata));

   // no field writes outside an active operation
   assert property (@(posedge clk) disable iff (!arst_n)
      (!ctr_req || ctr_ack) |=> $stable(conf_out))
      else log_error("conf_out changed while no operation was running");

   function automatic conf_t model_conf();
      conf_t c;
      for (int i = 0; i < conf_fields; i++) begin
         c[i*data_w +: data_w] = model_field[i];
      end
      return c;
   endfunction

   task automatic compare_conf();
      conf_t exp;
      exp = model_conf();
      assert (conf_out == exp) else log_mismatch("conf_out", exp, conf_out);
   endtask

   task automatic check_idle_outputs();
      assert (ctr_ack == 1'b0) else log_mismatch("ctr_ack", '0, conf_t'(ctr_ack));
      assert (ctr_rdata == '0) else log_mismatch("ctr_rdata", '0, conf_t'(ctr_rdata));
      assert (conf_out == '0) else log_mismatch("conf_out", '0, conf_out);
   endtask

   // one four-phase transfer, called a small delay after a rising edge
   task automatic bus_access(input logic rnw, input ctr_addr_t addr, input data_t wdata,
                             input int hold, input int exp_lat, input data_t exp_rdata);
      int lat;
      lat = 0;
      ctr_req  = 1'b1;
      ctr_rnw  = rnw;
      ctr_addr = addr;
      ctr_data = wdata;
      // first edge seeing req is E0
      @(posedge clk);
      #1;
      while (!ctr_ack) begin
         @(posedge clk);
         #1;
         lat++;
      end
      assert (lat == exp_lat)
         else log_mismatch("ctr_ack latency", conf_t'(exp_lat), conf_t'(lat));
      assert (ctr_rdata == exp_rdata)
         else log_mismatch("ctr_rdata", conf_t'(exp_rdata), conf_t'(ctr_rdata));
      // back-pressure with req held past ack
      for (int i = 0; i < hold; i++) begin
         @(posedge clk);
         #1;
      end
      ctr_req = 1'b0;
      ctr_rnw = 1'b0;
      @(posedge clk);
      #1;
      while (ctr_ack) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic write_field(input int idx, input data_t val, input int hold);
      bus_access(1'b0, ctr_addr_t'(idx), val, hold, 1, '0);
      model_field[idx] = val;
   endtask

   task automatic read_field(input int idx, input int hold);
      bus_access(1'b1, ctr_addr_t'(idx), '0, hold, 1, model_field[idx]);
   endtask

   task automatic save_slot(input int slot, input int hold);
      bus_access(1'b0, ctr_addr_t'(int'(conf_mem_base) + slot), '0, hold, conf_fields + 1, '0);
      model_slot[slot] = model_field;
   endtask

   task automatic load_slot(input int slot, input int hold);
      bus_access(1'b1, ctr_addr_t'(int'(conf_mem_base) + slot), '0, hold, conf_fields + 2, '0);
      model_field = model_slot[slot];
      compare_conf();
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (fail_cnt == errs_before) begin
         tests_passed++;
         $display("test %s: passed", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, fail_cnt - errs_before);
      end
   endtask

   initial begin
      int cycle_cnt;
      cycle_cnt = 0;
      while (cycle_cnt < timeout_cycles) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout after %0d cycles, the tests did not complete", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      int errs;
      int order [conf_slots];
      int j;
      int tmp;
      int hold;
      void'($urandom(32'h81dc716d));
      arst_n   = 1'b0;
      ctr_req  = 1'b0;
      ctr_rnw  = 1'b0;
      ctr_addr = '0;
      ctr_data = '0;
      for (int i = 0; i < conf_fields; i++) begin
         model_field[i] = '0;
      end

      // test 1, outputs idle through and after reset
      errs = fail_cnt;
      repeat (reset_cycles) begin
         @(posedge clk);
         #1;
         check_idle_outputs();
      end
      arst_n = 1'b1;
      repeat (2) begin
         @(posedge clk);
         #1;
         check_idle_outputs();
      end
      finish_test("reset", errs);

      // test 2
      errs = fail_cnt;
      for (int i = 0; i < conf_fields; i++) begin
         write_field(i, data_t'($urandom()), 0);
      end
      compare_conf();
      for (int i = 0; i < conf_fields; i++) begin
         read_field(i, 0);
      end
      finish_test("field write and readback", errs);

      // test 3, new contents for every slot
      errs = fail_cnt;
      for (int s = 0; s < conf_slots; s++) begin
         for (int i = 0; i < conf_fields; i++) begin
            write_field(i, data_t'($urandom()), 0);
         end
         save_slot(s, 0);
      end
      for (int i = 0; i < conf_fields; i++) begin
         write_field(i, data_t'($urandom()), 0);
      end
      compare_conf();
      // shuffled load order
      for (int s = 0; s < conf_slots; s++) begin
         order[s] = s;
      end
      for (int s = conf_slots - 1; s > 0; s--) begin
         j = int'($urandom_range(s, 0));
         tmp = order[s];
         order[s] = order[j];
         order[j] = tmp;
      end
      for (int s = 0; s < conf_slots; s++) begin
         load_slot(order[s], 0);
      end
      finish_test("save and load", errs);

      // test 4, held req on every operation type
      errs = fail_cnt;
      hold = int'($urandom_range(max_hold, 1));
      j = int'($urandom_range(conf_fields - 1, 0));
      write_field(j, data_t'($urandom()), hold);
      compare_conf();
      hold = int'($urandom_range(max_hold, 1));
      read_field(j, hold);
      repeat ($urandom_range(max_gap, 1)) @(posedge clk);
      #1;
      j = int'($urandom_range(conf_slots - 1, 0));
      hold = int'($urandom_range(max_hold, 1));
      save_slot(j, hold);
      hold = int'($urandom_range(max_hold, 1));
      load_slot((j + 1) % conf_slots, hold);
      finish_test("handshake and latency", errs);

      // test 5, live fields differ from every slot so a stray save or load shows
      errs = fail_cnt;
      for (int i = 0; i < conf_fields; i++) begin
         write_field(i, data_t'($urandom()), 0);
      end
      bus_access(1'b0, 6'd8, data_t'($urandom()), 0, 1, '0);
      bus_access(1'b1, ctr_addr_t'($urandom_range(30, 9)), '0, 0, 1, '0);
      bus_access(1'b1, 6'd31, '0, 0, 1, '0);
      bus_access(1'b0, 6'd36, data_t'($urandom()), 0, 1, '0);
      bus_access(1'b1, 6'd63, '0, 0, 1, '0);
      bus_access(1'b0, ctr_addr_t'($urandom_range(62, 37)), data_t'($urandom()), 0, 1, '0);
      compare_conf();
      for (int s = 0; s < conf_slots; s++) begin
         load_slot(s, 0);
      end
      finish_test("unmapped addresses", errs);

      $display("summary: %0d tests passed, %0d tests failed, %0d errors",
               tests_passed, tests_failed, fail_cnt);
      if (tests_failed == 0 && fail_cnt == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* hdl/conf_top.sv */
module conf_top import conf_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,

   // control bus, four-phase req/ack
   input  logic      ctr_req,
   input  logic      ctr_rnw,
   input  ctr_addr_t ctr_addr,
   input  data_t     ctr_data,
   output logic      ctr_ack,
   output data_t     ctr_rdata,

   // to the data engine
   output conf_t     conf_out
);

   logic       cnt_clr;
   logic       cnt_en;
   field_idx_t cnt_idx;
   logic       cnt_last;

   conf_field_if i_field_if ();
   conf_mem_if   i_mem_if ();

   conf_sequencer i_conf_sequencer (
      .clk       (clk),
      .arst_n    (arst_n),
      .ctr_req   (ctr_req),
      .ctr_rnw   (ctr_rnw),
      .ctr_addr  (ctr_addr),
      .ctr_data  (ctr_data),
      .ctr_ack   (ctr_ack),
      .ctr_rdata (ctr_rdata),
      .fld       (i_field_if.master),
      .mem       (i_mem_if.master),
      .cnt_clr   (cnt_clr),
      .cnt_en    (cnt_en),
      .cnt_idx   (cnt_idx),
      .cnt_last  (cnt_last)
   );

   // field index for save and load
   conf_word_counter i_conf_word_counter (
      .clk      (clk),
      .arst_n   (arst_n),
      .cnt_clr  (cnt_clr),
      .cnt_en   (cnt_en),
      .cnt_idx  (cnt_idx),
      .cnt_last (cnt_last)
   );

   conf_reg_bank i_conf_reg_bank (
      .clk      (clk),
      .arst_n   (arst_n),
      .fld      (i_field_if.slave),
      .conf_out (conf_out)
   );

   conf_mem i_conf_mem (
      .clk (clk),
      .mem (i_mem_if.slave)
   );

endmodule

/* hdl/conf_mem.sv */
module conf_mem import conf_pkg::*; (
   input  logic      clk,
   conf_mem_if.slave mem
);

   // all slots, one field per word
   data_t store [conf_slots * conf_fields];

   always_ff @(posedge clk) begin
      if (mem.mem_we) begin
         store[mem.mem_addr] <= mem.mem_wdata;
      end
   end

   // registered read, one cycle latency
   always_ff @(posedge clk) begin
      mem.mem_rdata <= store[mem.mem_addr];
   end

endmodule

/* hdl/conf_reg_bank.sv */
module conf_reg_bank import conf_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   conf_field_if.slave fld,
   output conf_t       conf_out
);

   data_t field_q [conf_fields];

   // one field per write
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         field_q <= '{default: '0};
      end else if (fld.field_we) begin
         field_q[fld.field_idx] <= fld.field_wdata;
      end
   end

   // combinational read of the selected field
   assign fld.field_rdata = field_q[fld.field_idx];

   // field 0 in the low bits
   always_comb begin
      for (int i = 0; i < conf_fields; i++) begin
         conf_out[i*data_w +: data_w] = field_q[i];
      end
   end

endmodule

/* hdl/conf_sequencer.sv */
module conf_sequencer import conf_pkg::*; (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         ctr_req,
   input  logic         ctr_rnw,
   input  ctr_addr_t    ctr_addr,
   input  data_t        ctr_data,
   output logic         ctr_ack,
   output data_t        ctr_rdata,
   conf_field_if.master fld,
   conf_mem_if.master   mem,
   output logic         cnt_clr,
   output logic         cnt_en,
   input  field_idx_t   cnt_idx,
   input  logic         cnt_last
);

   seq_state_t state_q;
   seq_state_t state_d;

   logic       reg_hit;
   logic       mem_hit;
   ctr_addr_t  mem_off;

   // register read in progress, selects rdata at response
   logic       reg_rd_q;
   slot_t      slot_q;

   // load pipeline: memory read issued, field write one cycle later
   logic       ld_issue;
   logic       ld_pend_q;
   logic       ld_last_q;
   field_idx_t ld_idx_q;

   // address decode
   always_comb begin
      mem_off = ctr_addr - conf_mem_base;
      reg_hit = (ctr_addr < conf_reg_offset);
      mem_hit = (ctr_addr >= conf_mem_base) && (mem_off < conf_slots);
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         idle: begin
            if (ctr_req) begin
               if (mem_hit) begin
                  state_d = ctr_rnw ? load : save;
               end else begin
                  // register or unmapped, both answer after one cycle
                  state_d = reg_acc;
               end
            end
         end
         reg_acc: begin
            state_d = ack_hold;
         end
         save: begin
            if (cnt_last) begin
               state_d = reg_acc;
            end
         end
         load: begin
            // stay until the last field write has gone through
            if (ld_last_q) begin
               state_d = reg_acc;
            end
         end
         ack_hold: begin
            if (!ctr_req) begin
               state_d = idle;
            end
         end
         default: begin
            state_d = idle;
         end
      endcase
   end

   assign ld_issue = (state_q == load) && !ld_last_q;

   // counter starts every transfer from field 0
   assign cnt_clr = (state_q == idle) && ctr_req && mem_hit;
   assign cnt_en  = (state_q == save) || ld_issue;

   // register bank port
   always_comb begin
      fld.field_we    = 1'b0;
      fld.field_idx   = ctr_addr[field_idx_w-1:0];
      fld.field_wdata = ctr_data;
      if (ld_pend_q) begin
         fld.field_we    = 1'b1;
         fld.field_idx   = ld_idx_q;
         fld.field_wdata = mem.mem_rdata;
      end else if (state_q == save) begin
         fld.field_idx = cnt_idx;
      end else if (state_q == idle) begin
         // bus write lands at the decode edge
         fld.field_we = ctr_req && reg_hit && !ctr_rnw;
      end
   end

   // memory port, save writes and load reads share the address
   assign mem.mem_we    = (state_q == save);
   assign mem.mem_addr  = {slot_q, cnt_idx};
   assign mem.mem_wdata = fld.field_rdata;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q   <= idle;
         ctr_ack   <= 1'b0;
         ctr_rdata <= '0;
         reg_rd_q  <= 1'b0;
         ld_pend_q <= 1'b0;
         ld_last_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         ld_pend_q <= ld_issue;
         ld_last_q <= ld_issue && cnt_last;
         if (state_q == idle) begin
            reg_rd_q <= reg_hit && ctr_rnw;
         end
         if (state_q == reg_acc) begin
            ctr_ack   <= 1'b1;
            ctr_rdata <= reg_rd_q ? fld.field_rdata : '0;
         end else if ((state_q == ack_hold) && !ctr_req) begin
            ctr_ack   <= 1'b0;
            ctr_rdata <= '0;
         end
      end
   end

   // slot and load index
   always_ff @(posedge clk) begin
      if (state_q == idle) begin
         slot_q <= mem_off[slot_w-1:0];
      end
      ld_idx_q <= cnt_idx;
   end

endmodule

/* hdl/conf_word_counter.sv */
module conf_word_counter import conf_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       cnt_clr,
   input  logic       cnt_en,
   output field_idx_t cnt_idx,
   output logic       cnt_last
);

   // index of the last field in a configuration
   localparam field_idx_t last_idx = field_idx_t'(conf_fields - 1);

   // clear wins over increment
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt_idx <= '0;
      end else if (cnt_clr) begin
         cnt_idx <= '0;
      end else if (cnt_en) begin
         // wraps back to field 0 after the last one
         cnt_idx <= cnt_idx + 1'b1;
      end
   end

   // transfer ends on this field
   assign cnt_last = (cnt_idx == last_idx);

endmodule

/* hdl/conf_mem_if.sv */
interface conf_mem_if import conf_pkg::*; ();

   logic      mem_we;

   // slot in the upper bits, field in the lower bits
   mem_addr_t mem_addr;
   data_t     mem_wdata;

   // word at last cycle's address
   data_t     mem_rdata;

   modport master (
      output mem_we,
      output mem_addr,
      output mem_wdata,
      input  mem_rdata
   );

   modport slave (
      input  mem_we,
      input  mem_addr,
      input  mem_wdata,
      output mem_rdata
   );

endinterface

/* hdl/conf_field_if.sv */
interface conf_field_if import conf_pkg::*; ();

   // write strobe, applied at the clock edge
   logic       field_we;

   // selects both the write target and the read field
   field_idx_t field_idx;
   data_t      field_wdata;
   data_t      field_rdata;

   modport master (
      output field_we,
      output field_idx,
      output field_wdata,
      input  field_rdata
   );

   modport slave (
      input  field_we,
      input  field_idx,
      input  field_wdata,
      output field_rdata
   );

endinterface

/* hdl/conf_pkg.sv */
package conf_pkg;

   // data word and configuration field share one width
   localparam int unsigned data_w = 16;

   // fields per configuration
   localparam int unsigned conf_fields = 8;
   localparam int unsigned conf_bits = conf_fields * data_w;
   localparam int unsigned field_idx_w = 3;

   // saved configurations in the store
   localparam int unsigned conf_slots = 4;
   localparam int unsigned slot_w = 2;

   // memory word address is slot then field index
   localparam int unsigned mem_addr_w = slot_w + field_idx_w;

   // control bus address map
   localparam int unsigned ctr_addr_w = 6;

   // first address above the field registers
   localparam logic [ctr_addr_w-1:0] conf_reg_offset = 6'd8;

   // slots start here, one address per slot
   localparam logic [ctr_addr_w-1:0] conf_mem_base = 6'd32;

   typedef logic [data_w-1:0]      data_t;
   typedef logic [conf_bits-1:0]   conf_t;
   typedef logic [field_idx_w-1:0] field_idx_t;
   typedef logic [slot_w-1:0]      slot_t;
   typedef logic [mem_addr_w-1:0]  mem_addr_t;
   typedef logic [ctr_addr_w-1:0]  ctr_addr_t;

   // sequencer states
   typedef enum logic [2:0] {
      idle,
      reg_acc,
      save,
      load,
      ack_hold
   } seq_state_t;

endpackage
